//--- Makefile
VERILATOR ?= verilator
TOP       ?= ks_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+test
common/ks_pkg.sv
source/noise_lfsr.sv
source/trig_debounce.sv
source/delay_ram.sv
voice/loop_filter.sv
voice/ks_voice.sv
source/ks_synth_top.sv
test/ks_tb.sv

//--- common/ks_pkg.sv
package ks_pkg;

	// widths
	localparam int sample_w = 24; // audio word
	localparam int noise_w  = 16; // lfsr word
	localparam int vel_w    = 7;  // note velocity
	localparam int decay_w  = 12; // sustain gain
	localparam int addr_w   = 10; // delay line address

	// feedback gain is decay / 2^decay_shift, always below unity
	localparam int decay_shift = 12;

	// noise source
	localparam logic [noise_w-1:0] lfsr_seed = 16'hace1; // any nonzero start
	localparam logic [noise_w-1:0] lfsr_taps = 16'hd008; // x^16+x^15+x^13+x^4+1

	// loop filter
	localparam int filt_max_taps = 8;
	localparam int filt_log2     = $clog2(filt_max_taps); // largest filt_sel
	localparam int filt_acc_w    = sample_w + filt_log2;  // 8-tap sum headroom

	typedef logic signed [sample_w-1:0] sample_t; // audio sample
	typedef logic signed [noise_w-1:0]  noise_t;  // raw noise
	typedef logic        [addr_w-1:0]   addr_t;   // delay line index

	// same codes as the older voice FSM
	typedef enum logic [1:0] {
		st_idle     = 2'b00, // pre-fill, silent
		st_load     = 2'b01, // noise burst into the line
		st_feedback = 2'b10  // string ringing
	} voice_state_t;

	// note settings, top to voice
	typedef struct packed {
		logic [vel_w-1:0]   velocity;     // noise scale
		logic [decay_w-1:0] decay;        // feedback gain
		addr_t              delay_length; // tuning
		logic [1:0]         filt_sel;     // 1, 2, 4 or 8 taps
	} voice_ctrl_t;

endpackage

//--- source/delay_ram.sv
`timescale 1ns/10ps

module delay_ram (
	input  logic            a_clk,
	input  logic            reset_n,
	input  logic            sample_en,
	input  logic            wr_en,
	input  logic            rd_en,
	input  ks_pkg::addr_t   addr,
	input  ks_pkg::sample_t wr_data,
	output ks_pkg::sample_t rd_data
);
	import ks_pkg::*;

	sample_t mem [2**addr_w]; // one string's worth of samples

	// write port, one word per strobe
	always_ff @(posedge a_clk)
	begin
		if (sample_en && wr_en)
		begin
			mem[addr] <= wr_data;
		end
	end

	// registered read sees the old word at addr
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			rd_data <= '0;
		end
		else if (sample_en)
		begin
			if (rd_en)
			begin
				rd_data <= mem[addr];
			end
			else
			begin
				rd_data <= '0; // muted line
			end
		end
	end

endmodule

//--- source/ks_synth_top.sv
`timescale 1ns/10ps

module ks_synth_top (
	input  logic                a_clk,
	input  logic                reset_n,
	input  logic                sample_en,
	input  logic                trig,
	input  ks_pkg::voice_ctrl_t ctrl,
	output ks_pkg::sample_t     qout,
	output logic                playing
);

	logic           trig_pulse; // one clock per clean press
	ks_pkg::noise_t noise;      // excitation

	trig_debounce u_debounce (
		.a_clk      (a_clk),
		.reset_n    (reset_n),
		.trig       (trig),
		.trig_pulse (trig_pulse)
	);

	noise_lfsr u_lfsr (
		.a_clk     (a_clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.noise     (noise)
	);

	ks_voice u_voice (
		.a_clk      (a_clk),
		.reset_n    (reset_n),
		.sample_en  (sample_en),
		.trig_pulse (trig_pulse),
		.noise      (noise),
		.ctrl       (ctrl),
		.qout       (qout),
		.playing    (playing)
	);

endmodule

//--- source/noise_lfsr.sv
`timescale 1ns/10ps

module noise_lfsr (
	input  logic           a_clk,
	input  logic           reset_n,
	input  logic           sample_en,
	output ks_pkg::noise_t noise
);
	import ks_pkg::*;

	logic [noise_w-1:0] lfsr; // galois state

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			lfsr <= lfsr_seed; // never zero
		end
		else if (sample_en)
		begin
			// shift right, fold taps back in when lsb falls out
			lfsr <= {1'b0, lfsr[noise_w-1:1]} ^ ({noise_w{lfsr[0]}} & lfsr_taps);
		end
	end

	assign noise = noise_t'(lfsr); // two's complement view

	// zero is the lock-up state of an xor lfsr
	a_lfsr_alive: assert property (@(posedge a_clk) disable iff (reset_n)
		lfsr != '0)
		else $error("noise lfsr stuck at zero");

endmodule

//--- source/trig_debounce.sv
`timescale 1ns/10ps

module trig_debounce (
	input  logic a_clk,
	input  logic reset_n,
	input  logic trig,
	output logic trig_pulse
);

	logic       trig_sync_0; // first sync stage
	logic       trig_sync_1; // safe to use
	logic       trig_now;    // accepted level
	logic [1:0] trig_cnt;    // cycles of disagreement
	logic       trig_idle;
	logic       trig_cnt_max;

	assign trig_idle    = (trig_sync_1 == trig_now); // nothing new
	assign trig_cnt_max = &trig_cnt;                 // 4th differing cycle

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			trig_sync_0 <= 1'b0;
			trig_sync_1 <= 1'b0;
			trig_now    <= 1'b0;
			trig_cnt    <= '0;
			trig_pulse  <= 1'b0;
		end
		else
		begin
			trig_sync_0 <= trig;
			trig_sync_1 <= trig_sync_0;
			trig_pulse  <= 1'b0;
			if (trig_idle)
			begin
				trig_cnt <= '0; // bounce or steady, start over
			end
			else
			begin
				trig_cnt <= trig_cnt + 1'b1;
				if (trig_cnt_max)
				begin
					trig_now   <= trig_sync_1; // level held long enough
					trig_pulse <= trig_sync_1; // press only, release is silent
				end
			end
		end
	end

	// accepting a level clears the disagreement, so a second pulse can't follow
	a_pulse_single: assert property (@(posedge a_clk) disable iff (reset_n)
		trig_pulse |=> !trig_pulse)
		else $error("trigger pulse longer than one clock");

endmodule

//--- test/ks_tb_tasks.svh
// one sample_en strobe, returns on the falling edge after it
task automatic next_strobe();
	@(posedge a_clk);
	while (!sample_en)
	begin
		@(posedge a_clk);
	end
	@(negedge a_clk); // outputs settled here
endtask

task automatic wait_strobes(input int n);
	repeat (n)
	begin
		next_strobe();
	end
endtask

// hold the button for a number of clocks, then let go
task automatic press(input int hold);
	@(negedge a_clk);
	trig = 1'b1;
	repeat (hold)
	begin
		@(negedge a_clk);
	end
	trig = 1'b0;
endtask

task automatic glitch(input int width);
	press(width); // same drive, shorter than the debounce count
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
	if (act !== exp)
	begin
		errors++;
		$display("Fail %s: expected %h, got %h at %0t", name, exp, act, $time);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
	begin
		errors++;
		$display("Fail %s: expected %h, got %h at %0t", name, exp, act, $time);
	end
endtask

function automatic longint magnitude(input sample_t x);
	return (x < 0) ? -longint'(x) : longint'(x);
endfunction

// filtered output may not outgrow its first period
task automatic check_peak(input longint limit, input sample_t act);
	if (magnitude(act) > limit)
	begin
		errors++;
		$display("Fail qout: magnitude %h above peak %h at %0t", magnitude(act), limit, $time);
	end
endtask

// decay gain, sample times decay then arithmetic shift by decay_shift
function automatic sample_t gain_ref(input sample_t x, input logic [decay_w-1:0] d);
	longint prod;
	prod = longint'(x) * longint'(d); // d zero extended, x sign extended
	return sample_t'(prod >>> decay_shift);
endfunction

//--- test/ks_tb.sv
`timescale 1ns/10ps

module ks_tb;
	import ks_pkg::*;

	localparam int clk_half    = 50;               // 100 ns clock
	localparam int max_p       = 202;              // loop at delay_length 200
	localparam int run_strobes = 30 * max_p + 400; // every test at its longest
	localparam int timeout_ns  = run_strobes * 8 * clk_half + 20000;

	logic        a_clk      = 1'b0;
	logic        sample_en  = 1'b0;
	logic [1:0]  strobe_div = '0;
	logic        reset_n;
	logic        trig;
	voice_ctrl_t ctrl;
	sample_t     qout;
	logic        playing;
	int          errors;
	int          seed;

	ks_synth_top uut (
		.a_clk     (a_clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.trig      (trig),
		.ctrl      (ctrl),
		.qout      (qout),
		.playing   (playing)
	);

	`include "ks_tb_tasks.svh"

	always #clk_half a_clk = ~a_clk;

	// one strobe every fourth clock
	always @(negedge a_clk)
	begin
		strobe_div <= strobe_div + 1'b1;
		sample_en  <= (strobe_div == 2'd3);
	end

	task automatic apply_reset();
		@(negedge a_clk);
		reset_n = 1'b1; // high means reset
		repeat (3)
		begin
			@(negedge a_clk);
		end
		reset_n = 1'b0;
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	// set up the note and pluck the string
	task automatic start_note(input int len, input int vel, input int dec, input int sel);
		ctrl.delay_length = addr_t'(len);
		ctrl.velocity     = vel[vel_w-1:0];
		ctrl.decay        = dec[decay_w-1:0];
		ctrl.filt_sel     = sel[1:0];
		press(10);
		for (int i = 0; i < 3 && !playing; i++)
		begin
			next_strobe();
		end
		if (!playing)
		begin
			errors++;
			$display("voice did not start within 3 strobes of a clean press");
		end
	endtask

	// last 3 of 4 periods checked against one period back
	task automatic check_recurrence(input int p, input logic [decay_w-1:0] dec);
		sample_t seen [$];
		for (int n = 0; n < 4 * p; n++)
		begin
			next_strobe();
			seen.push_back(qout);
			if (n >= p)
			begin
				check_sample("qout", gain_ref(seen[n - p], dec), qout);
			end
		end
	endtask

	task automatic test_idle();
		apply_reset();
		for (int n = 0; n < 50; n++)
		begin
			next_strobe();
			check_bit("playing", 1'b0, playing);
			check_sample("qout", '0, qout);
		end
	endtask

	task automatic test_debounce();
		apply_reset();
		glitch(2);
		repeat (10)
		begin
			next_strobe();
			check_bit("playing", 1'b0, playing); // glitch ignored
		end
		start_note(30, 100, 4080, 0);
		repeat (40) // through the load and into feedback
		begin
			next_strobe();
			check_bit("playing", 1'b1, playing);
		end
		// second pluck held through its own load and one settled period
		press(4 * (31 + 2 * 32) + 40);
		check_recurrence(32, 12'd4080); // a release pluck would break the loop
	endtask

	task automatic test_recurrence();
		int len;
		int dec;
		len = rand_range(20, 200);
		dec = rand_range(1, 4095);
		apply_reset();
		start_note(len, 100, dec, 0);
		wait_strobes(len + 1 + 2 * (len + 2)); // load plus two periods
		check_recurrence(len + 2, dec[decay_w-1:0]);
	endtask

	task automatic test_silence();
		int len;
		len = rand_range(20, 200);
		apply_reset();
		start_note(len, 0, 4095, 0); // no excitation
		for (int n = 0; n < len + 1 + 3 * (len + 2); n++)
		begin
			next_strobe();
			check_bit("playing", 1'b1, playing);
			check_sample("qout", '0, qout);
		end
		apply_reset();
		start_note(len, rand_range(1, 127), 0, 0); // no feedback
		wait_strobes(len + 1 + (len + 2) + 1);
		for (int n = 0; n < 2 * (len + 2); n++)
		begin
			next_strobe();
			check_sample("qout", '0, qout);
		end
	endtask

	task automatic test_filter_retrigger();
		int     len;
		longint peak;
		len  = rand_range(100, 200);
		peak = 0;
		apply_reset();
		start_note(len, 100, 3840, 3);
		wait_strobes(len + 1);
		for (int n = 0; n < len + 2; n++) // first period gives the ceiling
		begin
			next_strobe();
			if (magnitude(qout) > peak)
			begin
				peak = magnitude(qout);
			end
		end
		for (int n = 0; n < 3 * (len + 2); n++)
		begin
			next_strobe();
			check_peak(peak, qout);
		end
		ctrl.filt_sel = 2'd0; // plain loop again
		press(10);            // pluck while ringing
		for (int n = 0; n < len + 3 + 2 * (len + 2); n++)
		begin
			next_strobe();
			check_bit("playing", 1'b1, playing);
		end
		check_recurrence(len + 2, 12'd3840);
	endtask

	initial
	begin
		reset_n = 1'b1;
		trig    = 1'b0;
		ctrl    = '0;
		errors  = 0;
		seed    = 32'he71c;
		test_idle();
		test_debounce();
		test_recurrence();
		test_silence();
		test_filter_retrigger();
		$display("errors: %0d", errors);
		if (errors == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

	// hung run guard
	initial
	begin
		#(timeout_ns);
		$display("timeout, the tests did not finish within %0d ns", timeout_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- voice/ks_voice.sv
`timescale 1ns/10ps

module ks_voice (
	input  logic                a_clk,
	input  logic                reset_n,
	input  logic                sample_en,
	input  logic                trig_pulse,
	input  ks_pkg::noise_t      noise,
	input  ks_pkg::voice_ctrl_t ctrl,
	output ks_pkg::sample_t     qout,
	output logic                playing
);
	import ks_pkg::*;

	voice_state_t state;
	logic         press_pend; // press waiting for a strobe
	logic         press;
	addr_t        addr_cnt;   // shared rd/wr address
	addr_t        len_q;      // delay_length taken at the press
	logic         wr_en;
	logic         rd_en;
	sample_t      wr_data;
	sample_t      rd_data;
	sample_t      noise_scaled;
	sample_t      fb_data;
	logic signed [sample_w+decay_w:0] gain_prod;  // full product
	logic signed [sample_w+decay_w:0] gain_shift;

	assign press = press_pend | trig_pulse; // a pulse on the strobe counts too

	// velocity is unsigned, widen before the signed multiply
	assign noise_scaled = noise * $signed({1'b0, ctrl.velocity});

	// decay gain on the filter output
	assign gain_prod  = qout * $signed({1'b0, ctrl.decay});
	assign gain_shift = gain_prod >>> decay_shift;
	assign fb_data    = gain_shift[sample_w-1:0]; // gain < 1, no overflow

	always_comb
	begin
		wr_en   = 1'b1;
		rd_en   = 1'b0;
		wr_data = noise_scaled;
		case (state)
			st_idle, st_load: wr_data = noise_scaled; // pre-fill or burst
			st_feedback:
			begin
				rd_en   = 1'b1; // line only read once it is full
				wr_data = fb_data;
			end
			default:
			begin
				wr_en   = 1'b0;
				wr_data = '0;
			end
		endcase
	end

	assign playing = (state == st_load) || (state == st_feedback);

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state      <= st_idle;
			press_pend <= 1'b0;
			addr_cnt   <= '0;
			len_q      <= '0;
		end
		else
		begin
			if (sample_en)
			begin
				press_pend <= 1'b0; // used or dropped this strobe
			end
			else if (trig_pulse)
			begin
				press_pend <= 1'b1;
			end

			if (sample_en)
			begin
				case (state)
					st_idle:
					begin
						addr_cnt <= addr_cnt + 1'b1; // sweep whole ram
						if (press)
						begin
							state    <= st_load;
							addr_cnt <= '0;
							len_q    <= ctrl.delay_length;
						end
					end
					st_load:
					begin
						addr_cnt <= addr_cnt + 1'b1;
						if (addr_cnt >= len_q) // delay_length+1 words written
						begin
							state    <= st_feedback;
							addr_cnt <= '0;
						end
					end
					st_feedback:
					begin
						addr_cnt <= addr_cnt + 1'b1;
						if (press)
						begin
							state    <= st_load; // retrigger, fresh noise
							addr_cnt <= '0;
							len_q    <= ctrl.delay_length;
						end
						// ram period delay_length, plus read reg, filter and
						// write-back gives a loop of delay_length+2 strobes
						else if (len_q == '0 || addr_cnt == len_q - 1'b1)
						begin
							addr_cnt <= '0;
						end
					end
					default:
					begin
						state    <= st_load; // recover by replucking
						addr_cnt <= '0;
						len_q    <= ctrl.delay_length;
					end
				endcase
			end
		end
	end

	delay_ram u_ram (
		.a_clk     (a_clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.addr      (addr_cnt),
		.wr_data   (wr_data),
		.rd_data   (rd_data)
	);

	loop_filter u_filt (
		.a_clk     (a_clk),
		.reset_n   (reset_n),
		.sample_en (sample_en),
		.filt_sel  (ctrl.filt_sel),
		.din       (rd_data),
		.filt_out  (qout)
	);

	a_addr_range: assert property (@(posedge a_clk) disable iff (reset_n)
		(state != st_idle) |-> (addr_cnt <= len_q))
		else $error("delay address past delay length");

	// idle can only be left through a press on a strobe
	a_idle_quiet: assert property (@(posedge a_clk) disable iff (reset_n)
		(state == st_idle && !(sample_en && press)) |=> !playing)
		else $error("voice playing without a press");

endmodule

//--- voice/loop_filter.sv
`timescale 1ns/10ps

module loop_filter (
	input  logic            a_clk,
	input  logic            reset_n,
	input  logic            sample_en,
	input  logic [1:0]      filt_sel,
	input  ks_pkg::sample_t din,
	output ks_pkg::sample_t filt_out
);
	import ks_pkg::*;

	sample_t                     hist    [filt_max_taps];  // hist[0] is previous input
	logic signed [filt_acc_w-1:0] acc     [1:filt_log2]; // sum of last 2^k inputs
	logic signed [filt_acc_w-1:0] acc_nxt [1:filt_log2];
	logic signed [filt_acc_w-1:0] avg;                   // selected mean, wide

	always_comb
	begin
		// each window takes din in and drops the sample 2^k strobes old
		for (int k = 1; k <= filt_log2; k++)
		begin
			acc_nxt[k] = acc[k] + din - hist[(1 << k) - 1];
		end
		case (filt_sel)
			2'd0: avg = din;                // bypass, still registered
			2'd1: avg = acc_nxt[1] >>> 1;   // 2 taps
			2'd2: avg = acc_nxt[2] >>> 2;   // 4 taps
			default: avg = acc_nxt[3] >>> 3; // 8 taps, darkest
		endcase
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			hist     <= '{default: '0};
			acc      <= '{default: '0}; // matches the cleared history
			filt_out <= '0;
		end
		else if (sample_en)
		begin
			hist[0] <= din;
			for (int i = 1; i < filt_max_taps; i++)
			begin
				hist[i] <= hist[i-1];
			end
			// all windows run every strobe so filt_sel can change at any time
			for (int k = 1; k <= filt_log2; k++)
			begin
				acc[k] <= acc_nxt[k];
			end
			filt_out <= avg[sample_w-1:0]; // mean fits a sample
		end
	end

endmodule
